//--- bench/tb_cpu6809.sv
`timescale 1ns/1ps
`include "cpu6809_defs.svh"

module tb_cpu6809;

  localparam logic [15:0] PROG_BASE  = 16'h1000;
  localparam int          WAIT_LIMIT = 200;

  logic        clk;
  logic        reset_b;
  logic        halt_b;
  logic [7:0]  din;
  logic [15:0] addr;
  logic        data_rw_n;
  logic [7:0]  data_out;

  // 64 KiB memory, bus trace and write log
  logic [7:0]  mem [0:65535];
  logic [15:0] trace_q[$];
  logic [15:0] wr_addr_q[$];
  logic [7:0]  wr_data_q[$];
  logic [15:0] load_ptr;
  int          err_count;

  cpu6809_top dut_i (
    .clk       (clk),
    .reset_b   (reset_b),
    .halt_b    (halt_b),
    .din       (din),
    .addr      (addr),
    .data_rw_n (data_rw_n),
    .data_out  (data_out)
  );

  always #4 clk = ~clk;

  // Asynchronous read
  assign din = mem[addr];

  // One bus transfer per cycle, logged after reset release
  always @(posedge clk) begin
    if (reset_b) begin
      trace_q.push_back(addr);
      if (!data_rw_n) begin
        mem[addr] = data_out;
        wr_addr_q.push_back(addr);
        wr_data_q.push_back(data_out);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic report_fail(input string msg);
    err_count++;
    $display(">>> FAIL");
    $display("%s", msg);
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_eq16(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else
      report_fail($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_eq8(input string name, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp) else
      report_fail($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  // Fill depends on both address bytes
  task automatic fill_mem();
    for (int i = 0; i < 65536; i++) begin
      mem[i] = i[15:8] ^ {i[6:0], i[7]} ^ 8'h5A;
    end
  endtask

  task automatic start_program(input logic [15:0] base);
    fill_mem();
    mem[`CPU_RESET_VEC]         = base[15:8];
    mem[`CPU_RESET_VEC + 16'd1] = base[7:0];
    load_ptr                    = base;
  endtask

  task automatic emit(input logic [7:0] value);
    mem[load_ptr] = value;
    load_ptr      = load_ptr + 16'd1;
  endtask

  // Opcode with one operand byte
  task automatic emit2(input logic [7:0] opc, input logic [7:0] arg);
    emit(opc);
    emit(arg);
  endtask

  // Opcode with a big-endian 16-bit operand
  task automatic emit3(input logic [7:0] opc, input logic [15:0] arg);
    emit(opc);
    emit(arg[15:8]);
    emit(arg[7:0]);
  endtask

  task automatic reset_dut();
    @(posedge clk);
    reset_b <= 1'b0;
    @(posedge clk);
    trace_q.delete();
    wr_addr_q.delete();
    wr_data_q.delete();
    repeat (15) @(posedge clk);
    reset_b <= 1'b1;
  endtask

  task automatic wait_trace(input int count);
    int cycles;
    cycles = 0;
    while (trace_q.size() < count) begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) report_fail("timeout waiting for bus cycles");
    end
  endtask

  task automatic wait_writes(input int count);
    int cycles;
    cycles = 0;
    while (wr_addr_q.size() < count) begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) report_fail("timeout waiting for memory writes");
    end
  endtask

  // --------------------------------------------------------------------------
  // Reference model from the 6809 rules
  // --------------------------------------------------------------------------
  function automatic logic [7:0] expect_alu(input logic [7:0] opc, input logic [7:0] acc,
                                            input logic [7:0] imm);
    logic [7:0] r;
    r = acc;
    if (opc[7]) begin
      case (opc[3:0])
        4'h0: r = acc - imm;
        4'h4: r = acc & imm;
        4'h6: r = imm;
        4'h8: r = acc ^ imm;
        4'hA: r = acc | imm;
        4'hB: r = acc + imm;
        default: r = acc;
      endcase
    end else begin
      case (opc[3:0])
        4'h0: r = 8'h00 - acc;
        4'h3: r = ~acc;
        4'h4: r = {1'b0, acc[7:1]};
        4'h8: r = {acc[6:0], 1'b0};
        4'hA: r = acc - 8'h01;
        4'hC: r = acc + 8'h01;
        4'hF: r = 8'h00;
        default: r = acc;
      endcase
    end
    return r;
  endfunction

  // Flags after CMP lhs,rhs then the branch condition
  function automatic logic expect_taken(input logic [3:0] cond, input logic [7:0] lhs,
                                        input logic [7:0] rhs);
    logic [8:0] diff;
    logic       n;
    logic       z;
    logic       v;
    logic       c;
    diff = {1'b0, lhs} - {1'b0, rhs};
    c    = (lhs < rhs);
    n    = diff[7];
    z    = (diff[7:0] == 8'h00);
    v    = (lhs[7] != rhs[7]) && (diff[7] != lhs[7]);
    case (cond)
      4'h2: return !c && !z;
      4'h3: return c || z;
      4'h4: return !c;
      4'h5: return c;
      4'h6: return !z;
      4'h7: return z;
      4'h8: return !v;
      4'h9: return v;
      4'hA: return !n;
      4'hB: return n;
      4'hC: return n == v;
      4'hD: return n != v;
      4'hE: return !z && (n == v);
      default: return z || (n != v);
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic test_reset_vector();
    logic [15:0] vec;
    vec = 16'h0100 + 16'($urandom % 32'h7000);
    start_program(vec);
    emit(8'h20);
    emit(8'hFE);
    reset_dut();
    wait_trace(3);
    check_eq16("addr cycle 0", trace_q[0], 16'hFFFE);
    check_eq16("addr cycle 1", trace_q[1], 16'hFFFF);
    check_eq16("addr cycle 2", trace_q[2], vec);
  endtask

  task automatic test_alu();
    logic [7:0] ops [13];
    logic [7:0] opc;
    logic [7:0] x;
    logic [7:0] y;
    ops = '{8'h8B, 8'h80, 8'h84, 8'h8A, 8'h88, 8'h40, 8'h43,
            8'h44, 8'h48, 8'h4A, 8'h4C, 8'h4F, 8'h4D};
    for (int k = 0; k < 13; k++) begin
      for (int use_b = 0; use_b < 2; use_b++) begin
        x   = 8'($urandom);
        y   = 8'($urandom);
        opc = ops[k];
        // B forms sit one row over
        if (use_b == 1) opc = opc | (opc[7] ? 8'h40 : 8'h10);
        start_program(PROG_BASE);
        emit(use_b == 1 ? 8'hC6 : 8'h86);
        emit(x);
        emit(opc);
        if (opc[7]) emit(y);
        emit(use_b == 1 ? `OP_STB_EXT : `OP_STA_EXT);
        emit(8'h20);
        emit(8'h00);
        emit(8'h20);
        emit(8'hFE);
        reset_dut();
        wait_writes(1);
        check_eq16("store addr", wr_addr_q[0], 16'h2000);
        check_eq8($sformatf("result of op %h", opc), wr_data_q[0], expect_alu(opc, x, y));
      end
    end
  endtask

  task automatic test_wide();
    logic [15:0] vd;
    logic [15:0] vx;
    logic [15:0] vu;
    logic [15:0] exp_addr [8];
    logic [7:0]  exp_data [8];
    vd = 16'($urandom);
    vx = 16'($urandom);
    vu = 16'($urandom);
    start_program(PROG_BASE);
    emit3(`OP_LDD_IMM, vd);
    emit3(`OP_STD_EXT, 16'h2100);
    emit3(`OP_LDX_IMM, vx);
    emit3(`OP_STX_EXT, 16'h2102);
    emit3(`OP_LDU_IMM, vu);
    emit3(`OP_STU_EXT, 16'h2104);
    emit3(`OP_STA_EXT, 16'h2106);
    emit3(`OP_STB_EXT, 16'h2107);
    emit2(8'h20, 8'hFE);
    // High byte first, then A and B alone
    exp_data = '{vd[15:8], vd[7:0], vx[15:8], vx[7:0],
                 vu[15:8], vu[7:0], vd[15:8], vd[7:0]};
    for (int i = 0; i < 8; i++) exp_addr[i] = 16'h2100 + 16'(i);
    reset_dut();
    wait_writes(8);
    for (int i = 0; i < 8; i++) begin
      check_eq16($sformatf("write %0d addr", i), wr_addr_q[i], exp_addr[i]);
      check_eq8($sformatf("write %0d data", i), wr_data_q[i], exp_data[i]);
    end
  endtask

  task automatic test_branches();
    logic [7:0]  x;
    logic [7:0]  y;
    logic [15:0] exp;
    for (int cond = 2; cond < 16; cond++) begin
      // Equal operands first, then a random pair
      for (int pass = 0; pass < 2; pass++) begin
        x = 8'($urandom);
        y = (pass == 0) ? x : 8'($urandom);
        start_program(PROG_BASE);
        emit2(8'h86, x);
        emit2(8'h81, y);
        emit2(8'h20 | 8'(cond), 8'h10);
        emit2(8'h20, 8'hFE);
        mem[PROG_BASE + 16'h0016] = 8'h20;
        mem[PROG_BASE + 16'h0017] = 8'hFE;
        exp = expect_taken(4'(cond), x, y) ? PROG_BASE + 16'h0016 : PROG_BASE + 16'h0006;
        reset_dut();
        wait_trace(9);
        check_eq16("offset fetch addr", trace_q[7], PROG_BASE + 16'h0005);
        check_eq16($sformatf("addr after branch %h", 8'h20 | 8'(cond)), trace_q[8], exp);
      end
    end
  endtask

  task automatic test_halt();
    logic [7:0] x;
    x = 8'($urandom);
    start_program(PROG_BASE);
    emit2(8'h86, x);
    emit3(`OP_STA_EXT, 16'h2200);
    emit2(8'h20, 8'hFE);
    @(posedge clk);
    halt_b <= 1'b0;
    reset_dut();
    wait_trace(24);
    for (int i = 2; i < 24; i++) begin
      check_eq16($sformatf("halted addr %0d", i), trace_q[i], PROG_BASE);
    end
    assert (wr_addr_q.size() == 0) else report_fail("memory written while halted");
    halt_b <= 1'b1;
    wait_writes(1);
    check_eq16("store addr after halt", wr_addr_q[0], 16'h2200);
    check_eq8("store data after halt", wr_data_q[0], x);
  endtask

  initial begin
    clk       = 1'b0;
    reset_b   = 1'b0;
    halt_b    = 1'b1;
    err_count = 0;
    load_ptr  = '0;
    void'($urandom(32'h0e30a5d1));
    fill_mem();

    test_reset_vector();
    test_alu();
    test_wide();
    test_branches();
    test_halt();

    if (err_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- cpu6809.f
+incdir+hw
hw/cpu_isa_pkg.sv
hw/cpu_bus_pkg.sv
hw/fetch_ctrl.sv
hw/inst_decode.sv
hw/alu8.sv
hw/reg_file.sv
hw/lsu.sv
hw/cpu6809_top.sv
bench/tb_cpu6809.sv

//--- hw/alu8.sv
`timescale 1ns/1ps
`include "cpu6809_defs.svh"

module alu8 (
  input  cpu_bus_pkg::exec_cmd_t   cmd,
  input  logic [`CPU_DATA_W-1:0]   a,
  input  logic [`CPU_DATA_W-1:0]   b,
  input  logic [`CPU_DATA_W-1:0]   imm,
  input  logic [`CPU_DATA_W-1:0]   cc,
  output cpu_bus_pkg::alu_result_t result
);

  logic [`CPU_DATA_W-1:0] lhs;
  logic [`CPU_DATA_W-1:0] rhs;
  logic [`CPU_DATA_W-1:0] r;
  logic [`CPU_DATA_W:0]   wide;
  logic [4:0]             nib;
  logic                   h;
  logic                   v;
  logic                   c;

  // Left operand is the accumulator, right is the immediate byte
  assign lhs = (cmd.acc == cpu_isa_pkg::REG_B) ? b : a;
  assign rhs = cmd.use_imm ? imm : '0;

  always_comb begin
    // H and C kept unless the operation says otherwise
    h    = cc[cpu_isa_pkg::CC_H];
    c    = cc[cpu_isa_pkg::CC_C];
    v    = 1'b0;
    wide = '0;
    nib  = '0;
    r    = lhs;
    case (cmd.alu_op)
      cpu_isa_pkg::ALU_ADD: begin
        wide = {1'b0, lhs} + {1'b0, rhs};
        nib  = {1'b0, lhs[3:0]} + {1'b0, rhs[3:0]};
        r    = wide[7:0];
        c    = wide[8];
        h    = nib[4];
        v    = (lhs[7] == rhs[7]) && (r[7] != lhs[7]);
      end
      // Carry is the borrow out of bit 7
      cpu_isa_pkg::ALU_SUB, cpu_isa_pkg::ALU_CMP: begin
        wide = {1'b0, lhs} - {1'b0, rhs};
        r    = wide[7:0];
        c    = wide[8];
        v    = (lhs[7] != rhs[7]) && (r[7] != lhs[7]);
      end
      cpu_isa_pkg::ALU_AND:  r = lhs & rhs;
      cpu_isa_pkg::ALU_OR:   r = lhs | rhs;
      cpu_isa_pkg::ALU_EOR:  r = lhs ^ rhs;
      cpu_isa_pkg::ALU_LOAD: r = rhs;
      cpu_isa_pkg::ALU_CLR: begin
        r = '0;
        c = 1'b0;
      end
      cpu_isa_pkg::ALU_COM: begin
        r = ~lhs;
        c = 1'b1;
      end
      cpu_isa_pkg::ALU_NEG: begin
        r = 8'h00 - lhs;
        c = (r != 8'h00);
        v = (r == 8'h80);
      end
      cpu_isa_pkg::ALU_INC: begin
        r = lhs + 8'h01;
        v = (lhs == 8'h7F);
      end
      cpu_isa_pkg::ALU_DEC: begin
        r = lhs - 8'h01;
        v = (lhs == 8'h80);
      end
      cpu_isa_pkg::ALU_ASL: begin
        r = {lhs[6:0], 1'b0};
        c = lhs[7];
        v = lhs[7] ^ lhs[6];
      end
      // N falls out as zero from the shift
      cpu_isa_pkg::ALU_LSR: begin
        r = {1'b0, lhs[7:1]};
        c = lhs[0];
      end
      // TST and NOP pass the accumulator through
      default: r = lhs;
    endcase
  end

  assign result = '{value: r, h: h, n: r[7], z: (r == '0), v: v, c: c};

endmodule

//--- hw/cpu6809_defs.svh
`ifndef CPU6809_DEFS_SVH
`define CPU6809_DEFS_SVH

// Bus widths
`define CPU_ADDR_W 16
`define CPU_DATA_W 8

// High byte of the reset vector, the low byte sits at the next address
`define CPU_RESET_VEC 16'hFFFE

// Opcode groups by high nibble
`define OP_HI_BRANCH 4'h2
`define OP_HI_INH_A  4'h4
`define OP_HI_INH_B  4'h5
`define OP_HI_IMM_A  4'h8
`define OP_HI_IMM_B  4'hC

// 16-bit immediate loads
`define OP_LDX_IMM 8'h8E
`define OP_LDD_IMM 8'hCC
`define OP_LDU_IMM 8'hCE

// Extended stores
`define OP_STA_EXT 8'hB7
`define OP_STB_EXT 8'hF7
`define OP_STD_EXT 8'hFD
`define OP_STX_EXT 8'hBF
`define OP_STU_EXT 8'hFF

`endif

//--- hw/cpu6809_top.sv
`timescale 1ns/1ps
`include "cpu6809_defs.svh"

module cpu6809_top (
  input  logic                   clk,
  input  logic                   reset_b,
  input  logic                   halt_b,
  input  logic [`CPU_DATA_W-1:0] din,
  output logic [`CPU_ADDR_W-1:0] addr,
  output logic                   data_rw_n,
  output logic [`CPU_DATA_W-1:0] data_out
);

  cpu_bus_pkg::fetch_word_t fetch;
  cpu_bus_pkg::exec_cmd_t   cmd;
  cpu_bus_pkg::alu_result_t result;
  cpu_bus_pkg::mem_bus_t    bus;

  logic [`CPU_DATA_W-1:0]   a;
  logic [`CPU_DATA_W-1:0]   b;
  logic [`CPU_DATA_W-1:0]   cc;
  logic [2*`CPU_DATA_W-1:0] store_value;
  logic [`CPU_ADDR_W-1:0]   pc;
  logic [`CPU_ADDR_W-1:0]   vec_value;
  logic                     vec_load;
  logic                     bus_busy;

  fetch_ctrl fetch_ctrl_i (
    .clk       (clk),
    .reset_b   (reset_b),
    .halt_b    (halt_b),
    .din       (din),
    .vec_load  (vec_load),
    .vec_value (vec_value),
    .bus_busy  (bus_busy),
    .cc        (cc),
    .pc        (pc),
    .fetch     (fetch)
  );

  inst_decode inst_decode_i (
    .fetch (fetch),
    .cmd   (cmd)
  );

  // Immediate byte is always the first operand
  alu8 alu8_i (
    .cmd    (cmd),
    .a      (a),
    .b      (b),
    .imm    (fetch.op1),
    .cc     (cc),
    .result (result)
  );

  reg_file reg_file_i (
    .clk         (clk),
    .reset_b     (reset_b),
    .cmd         (cmd),
    .result      (result),
    .imm16       ({fetch.op1, fetch.op2}),
    .a           (a),
    .b           (b),
    .cc          (cc),
    .store_value (store_value)
  );

  lsu lsu_i (
    .clk         (clk),
    .reset_b     (reset_b),
    .din         (din),
    .pc          (pc),
    .fetch       (fetch),
    .store_value (store_value),
    .bus         (bus),
    .vec_load    (vec_load),
    .vec_value   (vec_value),
    .bus_busy    (bus_busy)
  );

  // Pin side, read is high
  assign addr      = bus.addr;
  assign data_rw_n = ~bus.we;
  assign data_out  = bus.wdata;

endmodule

//--- hw/cpu_bus_pkg.sv
`include "cpu6809_defs.svh"

package cpu_bus_pkg;

  // Instruction bytes as fetched
  // valid marks the one execute cycle of the instruction
  typedef struct packed {
    logic                   valid;
    logic [`CPU_DATA_W-1:0] opcode;
    logic [`CPU_DATA_W-1:0] op1;
    logic [`CPU_DATA_W-1:0] op2;
  } fetch_word_t;

  // One execute command per instruction
  typedef struct packed {
    cpu_isa_pkg::alu_op_e  alu_op;
    cpu_isa_pkg::reg_sel_e acc;
    logic                  use_imm;
    cpu_isa_pkg::reg_sel_e ld16;
    cpu_isa_pkg::reg_sel_e st_src;
  } exec_cmd_t;

  // ALU output byte and flags
  typedef struct packed {
    logic [`CPU_DATA_W-1:0] value;
    logic                   h;
    logic                   n;
    logic                   z;
    logic                   v;
    logic                   c;
  } alu_result_t;

  // Toward the memory pins
  typedef struct packed {
    logic [`CPU_ADDR_W-1:0] addr;
    logic                   we;
    logic [`CPU_DATA_W-1:0] wdata;
  } mem_bus_t;

endpackage

//--- hw/cpu_isa_pkg.sv
package cpu_isa_pkg;

  // Bit positions inside the CC byte
  typedef enum logic [2:0] {
    CC_C = 3'd0,
    CC_V = 3'd1,
    CC_Z = 3'd2,
    CC_N = 3'd3,
    CC_I = 3'd4,
    CC_H = 3'd5,
    CC_F = 3'd6,
    CC_E = 3'd7
  } cc_bit_e;

  // 8-bit ALU operations
  // NOP leaves every register and flag alone
  typedef enum logic [3:0] {
    ALU_NOP,
    ALU_ADD,
    ALU_SUB,
    ALU_CMP,
    ALU_AND,
    ALU_OR,
    ALU_EOR,
    ALU_LOAD,
    ALU_CLR,
    ALU_COM,
    ALU_NEG,
    ALU_INC,
    ALU_DEC,
    ALU_ASL,
    ALU_LSR,
    ALU_TST
  } alu_op_e;

  // Register choice for ALU, 16-bit load and store
  typedef enum logic [2:0] {
    REG_NONE,
    REG_A,
    REG_B,
    REG_D,
    REG_X,
    REG_U
  } reg_sel_e;

  // Short branch condition, low nibble of the 2x opcodes
  typedef enum logic [3:0] {
    BR_RA = 4'h0,
    BR_RN = 4'h1,
    BR_HI = 4'h2,
    BR_LS = 4'h3,
    BR_CC = 4'h4,
    BR_CS = 4'h5,
    BR_NE = 4'h6,
    BR_EQ = 4'h7,
    BR_VC = 4'h8,
    BR_VS = 4'h9,
    BR_PL = 4'hA,
    BR_MI = 4'hB,
    BR_GE = 4'hC,
    BR_LT = 4'hD,
    BR_GT = 4'hE,
    BR_LE = 4'hF
  } br_cond_e;

endpackage

//--- hw/fetch_ctrl.sv
`timescale 1ns/1ps
`include "cpu6809_defs.svh"

module fetch_ctrl (
  input  logic                     clk,
  input  logic                     reset_b,
  input  logic                     halt_b,
  input  logic [`CPU_DATA_W-1:0]   din,
  input  logic                     vec_load,
  input  logic [`CPU_ADDR_W-1:0]   vec_value,
  input  logic                     bus_busy,
  input  logic [`CPU_DATA_W-1:0]   cc,
  output logic [`CPU_ADDR_W-1:0]   pc,
  output cpu_bus_pkg::fetch_word_t fetch
);

  // One-hot fetch states
  localparam logic [3:0] ST_WAIT = 4'b0001;
  localparam logic [3:0] ST_OPC  = 4'b0010;
  localparam logic [3:0] ST_OP1  = 4'b0100;
  localparam logic [3:0] ST_OP2  = 4'b1000;

  logic [3:0]             state_q;
  logic [3:0]             state_d;
  logic [`CPU_DATA_W-1:0] ir_q;
  logic [`CPU_DATA_W-1:0] op1_q;
  logic [`CPU_DATA_W-1:0] op2_q;
  logic                   three_q;
  logic                   valid_q;
  logic                   valid_d;
  logic [`CPU_ADDR_W-1:0] pc_d;
  logic [`CPU_ADDR_W-1:0] pc_inc;
  logic [`CPU_ADDR_W-1:0] br_target;
  logic                   imm_lo;
  logic                   len_two;
  logic                   len_three;
  logic                   opc_go;
  logic                   taken;
  logic                   f_n;
  logic                   f_z;
  logic                   f_v;
  logic                   f_c;
  cpu_isa_pkg::br_cond_e  cond;

  // ------------------------------------------------------------------------
  // Opcode length from the byte on din
  // ------------------------------------------------------------------------
  always_comb begin
    // Immediate ALU forms kept in the 8x and Cx rows
    case (din[3:0])
      4'h0, 4'h1, 4'h4, 4'h6, 4'h8, 4'hA, 4'hB: imm_lo = 1'b1;
      default: imm_lo = 1'b0;
    endcase
    len_two = (din[7:4] == `OP_HI_BRANCH) ||
              (imm_lo && (din[7:4] == `OP_HI_IMM_A || din[7:4] == `OP_HI_IMM_B));
    case (din)
      `OP_LDX_IMM, `OP_LDD_IMM, `OP_LDU_IMM,
      `OP_STA_EXT, `OP_STB_EXT, `OP_STD_EXT,
      `OP_STX_EXT, `OP_STU_EXT: len_three = 1'b1;
      default: len_three = 1'b0;
    endcase
  end

  // Opcode taken unless the LSU owns the bus or halt is asserted
  assign opc_go = state_q[1] && !bus_busy && halt_b;

  // ------------------------------------------------------------------------
  // Short branch decision
  // ------------------------------------------------------------------------
  assign f_n  = cc[cpu_isa_pkg::CC_N];
  assign f_z  = cc[cpu_isa_pkg::CC_Z];
  assign f_v  = cc[cpu_isa_pkg::CC_V];
  assign f_c  = cc[cpu_isa_pkg::CC_C];
  assign cond = cpu_isa_pkg::br_cond_e'(ir_q[3:0]);

  always_comb begin
    case (cond)
      cpu_isa_pkg::BR_RA: taken = 1'b1;
      cpu_isa_pkg::BR_RN: taken = 1'b0;
      cpu_isa_pkg::BR_HI: taken = !(f_c || f_z);
      cpu_isa_pkg::BR_LS: taken = f_c || f_z;
      cpu_isa_pkg::BR_CC: taken = !f_c;
      cpu_isa_pkg::BR_CS: taken = f_c;
      cpu_isa_pkg::BR_NE: taken = !f_z;
      cpu_isa_pkg::BR_EQ: taken = f_z;
      cpu_isa_pkg::BR_VC: taken = !f_v;
      cpu_isa_pkg::BR_VS: taken = f_v;
      cpu_isa_pkg::BR_PL: taken = !f_n;
      cpu_isa_pkg::BR_MI: taken = f_n;
      cpu_isa_pkg::BR_GE: taken = !(f_n ^ f_v);
      cpu_isa_pkg::BR_LT: taken = f_n ^ f_v;
      cpu_isa_pkg::BR_GT: taken = !(f_z || (f_n ^ f_v));
      default:            taken = f_z || (f_n ^ f_v);
    endcase
  end

  // Offset is relative to the byte after it
  assign pc_inc    = pc + `CPU_ADDR_W'd1;
  assign br_target = pc_inc + {{(`CPU_ADDR_W-`CPU_DATA_W){din[7]}}, din};

  // ------------------------------------------------------------------------
  // Next state and PC
  // ------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    pc_d    = pc;
    valid_d = 1'b0;
    case (1'b1)
      state_q[0]: begin
        if (vec_load) begin
          pc_d    = vec_value;
          state_d = ST_OPC;
        end
      end
      state_q[1]: begin
        if (opc_go) begin
          pc_d = pc_inc;
          if (len_two || len_three) begin
            state_d = ST_OP1;
          end else begin
            valid_d = 1'b1;
          end
        end
      end
      state_q[2]: begin
        pc_d = (ir_q[7:4] == `OP_HI_BRANCH && taken) ? br_target : pc_inc;
        if (three_q) begin
          state_d = ST_OP2;
        end else begin
          state_d = ST_OPC;
          valid_d = 1'b1;
        end
      end
      state_q[3]: begin
        pc_d    = pc_inc;
        state_d = ST_OPC;
        valid_d = 1'b1;
      end
      default: state_d = ST_WAIT;
    endcase
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state_q <= ST_WAIT;
      pc      <= '0;
      valid_q <= 1'b0;
      three_q <= 1'b0;
    end else begin
      state_q <= state_d;
      pc      <= pc_d;
      valid_q <= valid_d;
      if (opc_go) begin
        three_q <= len_three;
      end
    end
  end

  // Instruction bytes
  always_ff @(posedge clk) begin
    if (opc_go) begin
      ir_q <= din;
    end
    if (state_q[2]) begin
      op1_q <= din;
    end
    if (state_q[3]) begin
      op2_q <= din;
    end
  end

  assign fetch = '{valid: valid_q, opcode: ir_q, op1: op1_q, op2: op2_q};

  state_onehot_a: assert property (@(posedge clk) disable iff (!reset_b)
    $onehot(state_q));

endmodule

//--- hw/inst_decode.sv
`timescale 1ns/1ps
`include "cpu6809_defs.svh"

module inst_decode (
  input  cpu_bus_pkg::fetch_word_t fetch,
  output cpu_bus_pkg::exec_cmd_t   cmd
);

  logic [3:0] hi;
  logic [3:0] lo;

  assign hi = fetch.opcode[7:4];
  assign lo = fetch.opcode[3:0];

  always_comb begin
    cmd = '0;
    if (fetch.valid) begin
      case (hi)
        // Inherent A/B, bit 4 picks the accumulator
        `OP_HI_INH_A, `OP_HI_INH_B: begin
          case (lo)
            4'h0: cmd.alu_op = cpu_isa_pkg::ALU_NEG;
            4'h3: cmd.alu_op = cpu_isa_pkg::ALU_COM;
            4'h4: cmd.alu_op = cpu_isa_pkg::ALU_LSR;
            4'h8: cmd.alu_op = cpu_isa_pkg::ALU_ASL;
            4'hA: cmd.alu_op = cpu_isa_pkg::ALU_DEC;
            4'hC: cmd.alu_op = cpu_isa_pkg::ALU_INC;
            4'hD: cmd.alu_op = cpu_isa_pkg::ALU_TST;
            4'hF: cmd.alu_op = cpu_isa_pkg::ALU_CLR;
            default: cmd.alu_op = cpu_isa_pkg::ALU_NOP;
          endcase
          cmd.acc = fetch.opcode[4] ? cpu_isa_pkg::REG_B : cpu_isa_pkg::REG_A;
        end
        // Immediate rows, bit 6 picks the accumulator
        `OP_HI_IMM_A, `OP_HI_IMM_B: begin
          case (lo)
            4'h0: cmd.alu_op = cpu_isa_pkg::ALU_SUB;
            4'h1: cmd.alu_op = cpu_isa_pkg::ALU_CMP;
            4'h4: cmd.alu_op = cpu_isa_pkg::ALU_AND;
            4'h6: cmd.alu_op = cpu_isa_pkg::ALU_LOAD;
            4'h8: cmd.alu_op = cpu_isa_pkg::ALU_EOR;
            4'hA: cmd.alu_op = cpu_isa_pkg::ALU_OR;
            4'hB: cmd.alu_op = cpu_isa_pkg::ALU_ADD;
            default: cmd.alu_op = cpu_isa_pkg::ALU_NOP;
          endcase
          cmd.acc     = fetch.opcode[6] ? cpu_isa_pkg::REG_B : cpu_isa_pkg::REG_A;
          cmd.use_imm = 1'b1;
        end
        default: cmd.alu_op = cpu_isa_pkg::ALU_NOP;
      endcase

      // Unlisted low nibbles fall out as no-ops
      if (cmd.alu_op == cpu_isa_pkg::ALU_NOP) begin
        cmd.acc     = cpu_isa_pkg::REG_NONE;
        cmd.use_imm = 1'b0;
      end

      case (fetch.opcode)
        `OP_LDX_IMM: cmd.ld16   = cpu_isa_pkg::REG_X;
        `OP_LDD_IMM: cmd.ld16   = cpu_isa_pkg::REG_D;
        `OP_LDU_IMM: cmd.ld16   = cpu_isa_pkg::REG_U;
        `OP_STA_EXT: cmd.st_src = cpu_isa_pkg::REG_A;
        `OP_STB_EXT: cmd.st_src = cpu_isa_pkg::REG_B;
        `OP_STD_EXT: cmd.st_src = cpu_isa_pkg::REG_D;
        `OP_STX_EXT: cmd.st_src = cpu_isa_pkg::REG_X;
        `OP_STU_EXT: cmd.st_src = cpu_isa_pkg::REG_U;
        default: cmd.ld16 = cpu_isa_pkg::REG_NONE;
      endcase
    end
  end

  // ALU, 16-bit load and store never share one command
  always_comb begin
    one_unit_a: assert ($countones({cmd.alu_op != cpu_isa_pkg::ALU_NOP,
                                    cmd.ld16 != cpu_isa_pkg::REG_NONE,
                                    cmd.st_src != cpu_isa_pkg::REG_NONE}) <= 1);
  end

endmodule

//--- hw/lsu.sv
`timescale 1ns/1ps
`include "cpu6809_defs.svh"

module lsu (
  input  logic                     clk,
  input  logic                     reset_b,
  input  logic [`CPU_DATA_W-1:0]   din,
  input  logic [`CPU_ADDR_W-1:0]   pc,
  input  cpu_bus_pkg::fetch_word_t fetch,
  input  logic [2*`CPU_DATA_W-1:0] store_value,
  output cpu_bus_pkg::mem_bus_t    bus,
  output logic                     vec_load,
  output logic [`CPU_ADDR_W-1:0]   vec_value,
  output logic                     bus_busy
);

  logic                   vec_hi_q;
  logic                   vec_lo_q;
  logic                   st_lo_q;
  logic [`CPU_DATA_W-1:0] vec_byte_q;
  logic [`CPU_ADDR_W-1:0] st_addr_q;
  logic [`CPU_DATA_W-1:0] st_data_q;
  logic                   st_start;
  logic                   st_wide;

  // Store opcodes, all but STA and STB write two bytes
  always_comb begin
    case (fetch.opcode)
      `OP_STA_EXT, `OP_STB_EXT: begin
        st_start = fetch.valid;
        st_wide  = 1'b0;
      end
      `OP_STD_EXT, `OP_STX_EXT, `OP_STU_EXT: begin
        st_start = fetch.valid;
        st_wide  = 1'b1;
      end
      default: begin
        st_start = 1'b0;
        st_wide  = 1'b0;
      end
    endcase
  end

  // ------------------------------------------------------------------------
  // Address mux: vector, store high byte, store low byte, then fetch
  // ------------------------------------------------------------------------
  always_comb begin
    bus = '{addr: pc, we: 1'b0, wdata: store_value[7:0]};
    if (vec_hi_q) begin
      bus.addr = `CPU_RESET_VEC;
    end else if (vec_lo_q) begin
      bus.addr = `CPU_RESET_VEC + `CPU_ADDR_W'd1;
    end else if (st_start) begin
      bus.addr  = {fetch.op1, fetch.op2};
      bus.we    = 1'b1;
      bus.wdata = store_value[15:8];
    end else if (st_lo_q) begin
      bus.addr  = st_addr_q;
      bus.we    = 1'b1;
      bus.wdata = st_data_q;
    end
  end

  assign vec_load  = vec_lo_q;
  assign vec_value = {vec_byte_q, din};
  assign bus_busy  = vec_hi_q || vec_lo_q || st_start || st_lo_q;

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      vec_hi_q <= 1'b1;
      vec_lo_q <= 1'b0;
      st_lo_q  <= 1'b0;
    end else begin
      vec_hi_q <= 1'b0;
      vec_lo_q <= vec_hi_q;
      st_lo_q  <= st_start && st_wide;
    end
  end

  // Vector high byte, second store address and low store byte
  // The command is gone by the second store cycle
  always_ff @(posedge clk) begin
    if (vec_hi_q) begin
      vec_byte_q <= din;
    end
    if (st_start) begin
      st_addr_q <= {fetch.op1, fetch.op2} + `CPU_ADDR_W'd1;
      st_data_q <= store_value[7:0];
    end
  end

  // No store may be sequenced before the vector is in
  vec_no_write_a: assert property (@(posedge clk) disable iff (!reset_b)
    (vec_hi_q || vec_lo_q) |-> !(st_start || st_lo_q));

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps
`include "cpu6809_defs.svh"

module reg_file (
  input  logic                     clk,
  input  logic                     reset_b,
  input  cpu_bus_pkg::exec_cmd_t   cmd,
  input  cpu_bus_pkg::alu_result_t result,
  input  logic [2*`CPU_DATA_W-1:0] imm16,
  output logic [`CPU_DATA_W-1:0]   a,
  output logic [`CPU_DATA_W-1:0]   b,
  output logic [`CPU_DATA_W-1:0]   cc,
  output logic [2*`CPU_DATA_W-1:0] store_value
);

  logic [2*`CPU_DATA_W-1:0] x_q;
  logic [2*`CPU_DATA_W-1:0] u_q;
  logic                     acc_wr;

  // CMP and TST only touch flags
  assign acc_wr = cmd.alu_op != cpu_isa_pkg::ALU_NOP &&
                  cmd.alu_op != cpu_isa_pkg::ALU_CMP &&
                  cmd.alu_op != cpu_isa_pkg::ALU_TST;

  // Byte stores go out on the high half
  always_comb begin
    case (cmd.st_src)
      cpu_isa_pkg::REG_A: store_value = {a, 8'h00};
      cpu_isa_pkg::REG_B: store_value = {b, 8'h00};
      cpu_isa_pkg::REG_D: store_value = {a, b};
      cpu_isa_pkg::REG_X: store_value = x_q;
      cpu_isa_pkg::REG_U: store_value = u_q;
      default:            store_value = '0;
    endcase
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      a   <= '0;
      b   <= '0;
      x_q <= '0;
      u_q <= '0;
      // E, F and I set out of reset
      cc  <= 8'hD0;
    end else begin
      if (cmd.alu_op != cpu_isa_pkg::ALU_NOP) begin
        if (acc_wr && cmd.acc == cpu_isa_pkg::REG_A) a <= result.value;
        if (acc_wr && cmd.acc == cpu_isa_pkg::REG_B) b <= result.value;
        cc[cpu_isa_pkg::CC_H] <= result.h;
        cc[cpu_isa_pkg::CC_N] <= result.n;
        cc[cpu_isa_pkg::CC_Z] <= result.z;
        cc[cpu_isa_pkg::CC_V] <= result.v;
        cc[cpu_isa_pkg::CC_C] <= result.c;
      end
      // 16-bit load, C kept
      if (cmd.ld16 != cpu_isa_pkg::REG_NONE) begin
        if (cmd.ld16 == cpu_isa_pkg::REG_D) {a, b} <= imm16;
        if (cmd.ld16 == cpu_isa_pkg::REG_X) x_q <= imm16;
        if (cmd.ld16 == cpu_isa_pkg::REG_U) u_q <= imm16;
        cc[cpu_isa_pkg::CC_N] <= imm16[15];
        cc[cpu_isa_pkg::CC_Z] <= (imm16 == '0);
        cc[cpu_isa_pkg::CC_V] <= 1'b0;
      end
      // Store flags from the value on the bus
      if (cmd.st_src != cpu_isa_pkg::REG_NONE) begin
        cc[cpu_isa_pkg::CC_N] <= store_value[15];
        cc[cpu_isa_pkg::CC_Z] <= (store_value == '0);
        cc[cpu_isa_pkg::CC_V] <= 1'b0;
      end
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the cpu6809 testbench with Verilator.
# The run passes only if the pass message appears in the log.

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -f cpu6809.f --top-module tb_cpu6809 -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q ">>> PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
